// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_mem_subsys
FILELIST  := all.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Some tests failed

SOURCES := $(wildcard include/*.svh verilog/*.sv testbench/*.sv testbench/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
+incdir+include
+incdir+testbench
verilog/mem_bus_pkg.sv
verilog/sram_axi_slave.sv
verilog/mem_bus_arbiter.sv
verilog/mem_subsys_top.sv
testbench/tb_mem_subsys.sv

// ==== include/mem_bus_defs.svh ====
`ifndef MEM_BUS_DEFS_SVH
`define MEM_BUS_DEFS_SVH

// bus widths
`define MEM_ADDR_W 32
`define MEM_DATA_W 32
`define MEM_STRB_W 4

// sram window, byte addressed
`define SRAM_WORDS 1024
`define SRAM_BASE 32'h8000_0000

// cycles from AR handshake to rvalid
`define SRAM_RD_LAT 5

`endif

// ==== testbench/tb_mem_tests.svh ====
`ifndef TB_MEM_TESTS_SVH
`define TB_MEM_TESTS_SVH

task automatic test_reset();
    @(negedge clk);
    check_flag("reset fetch rvalid", 1'b0, if_r_valid);
    check_flag("reset ls rvalid", 1'b0, ls_r_valid);
    check_flag("reset ls bvalid", 1'b0, ls_b_valid);
    check_flag("reset fetch arready", 1'b0, if_ar_ready);
    check_flag("reset ls arready", 1'b0, ls_ar_ready);
    check_flag("reset ls awready", 1'b0, ls_aw_ready);
    check_flag("reset ls wready", 1'b0, ls_w_ready);
endtask

task automatic test_write_read();
    logic [`MEM_ADDR_W-1:0] addr [6];
    for (int i = 0; i < 6; i++) begin
        addr[i] = `SRAM_BASE + 32'(4 * (i * 171 % `SRAM_WORDS));
        write_check($sformatf("write_read write %0d", i), addr[i], $random(seed), 4'hf, i % 3);
    end
    for (int i = 0; i < 6; i++) begin
        read_check($sformatf("write_read fetch %0d", i), 1'b0, addr[i]);
        read_check($sformatf("write_read ls %0d", i), 1'b1, addr[i]);
    end
endtask

task automatic test_strobes();
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_STRB_W-1:0] strb [4];
    addr = `SRAM_BASE + 32'h40;
    strb = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
    write_check("strobe base", addr, $random(seed), 4'hf, 2);
    for (int i = 0; i < 4; i++) begin
        write_check($sformatf("strobe %b", strb[i]), addr, $random(seed), strb[i], i % 3);
        read_check($sformatf("strobe %b read", strb[i]), i % 2 == 1, addr);
    end
endtask

task automatic test_shared();
    mem_bus_pkg::axi_r_t    exp_if;
    mem_bus_pkg::axi_r_t    exp_ls;
    mem_bus_pkg::axi_r_t    got_if;
    mem_bus_pkg::axi_r_t    got_ls;
    int                     done_if;
    int                     done_ls;
    int                     start;
    logic [`MEM_ADDR_W-1:0] a_if;
    logic [`MEM_ADDR_W-1:0] a_ls;
    exp_if.resp = mem_bus_pkg::OKAY;
    exp_ls.resp = mem_bus_pkg::OKAY;
    for (int i = 0; i < 5; i++) begin
        a_if = `SRAM_BASE + 32'(8 * i + 512);
        a_ls = a_if + 32'd4;
        write_check("shared setup", a_if, $random(seed), 4'hf, 0);
        write_check("shared setup", a_ls, $random(seed), 4'hf, 1);
        // a lone fetch grant moves the pointer on to load/store reads
        if (i % 2 == 1) begin
            read_check($sformatf("shared fetch alone %0d", i), 1'b0, a_if);
        end
        exp_if.data = shadow[word_of(a_if)];
        exp_ls.data = shadow[word_of(a_ls)];
        start = xfer_count;
        fork
            do_read("shared fetch", 1'b0, a_if, 0, got_if, done_if);
            do_read("shared ls", 1'b1, a_ls, 0, got_ls, done_ls);
        join
        check_r($sformatf("shared fetch %0d", i), exp_if, got_if);
        check_r($sformatf("shared ls %0d", i), exp_ls, got_ls);
        // pointer sits just past the previous grant
        check_flag($sformatf("shared fetch first %0d", i), i % 2 == 0, done_if < done_ls);
        check_flag($sformatf("shared fetch bound %0d", i), 1'b1,
                   done_if > start && done_if - start <= 2);
        check_flag($sformatf("shared ls bound %0d", i), 1'b1,
                   done_ls > start && done_ls - start <= 2);
    end
endtask

task automatic test_out_of_window();
    mem_bus_pkg::axi_r_t    exp_r;
    mem_bus_pkg::axi_r_t    got_r;
    mem_bus_pkg::axi_b_t    exp_b;
    mem_bus_pkg::axi_b_t    got_b;
    int                     done_at;
    logic [`MEM_ADDR_W-1:0] in_addr;
    logic [`MEM_ADDR_W-1:0] alias_addr;
    in_addr = `SRAM_BASE + 32'h80;
    // one window above, same low index bits
    alias_addr = in_addr + 32'(`SRAM_WORDS * 4);
    exp_r.data = '0;
    exp_r.resp = mem_bus_pkg::SLVERR;
    exp_b.resp = mem_bus_pkg::SLVERR;
    write_check("oow setup", in_addr, $random(seed), 4'hf, 0);
    do_read("oow ls read", 1'b1, 32'h0000_0100, 0, got_r, done_at);
    check_r("oow ls read", exp_r, got_r);
    do_read("oow fetch read", 1'b0, alias_addr, 0, got_r, done_at);
    check_r("oow fetch read", exp_r, got_r);
    ls_write("oow write", alias_addr, ~shadow[word_of(in_addr)], 4'hf, 2, 0, got_b);
    check_b("oow write", exp_b, got_b);
    read_check("oow aliased word", 1'b1, in_addr);
endtask

task automatic test_backpressure();
    mem_bus_pkg::axi_r_t    exp_r;
    mem_bus_pkg::axi_r_t    got_ls;
    mem_bus_pkg::axi_r_t    got_if;
    mem_bus_pkg::axi_b_t    exp_b;
    mem_bus_pkg::axi_b_t    got_b;
    int                     done_ls;
    int                     done_if;
    int                     stall;
    logic [`MEM_ADDR_W-1:0] a_ls;
    logic [`MEM_ADDR_W-1:0] a_if;
    logic [`MEM_DATA_W-1:0] data;
    exp_r.resp = mem_bus_pkg::OKAY;
    exp_b.resp = mem_bus_pkg::OKAY;
    for (int i = 0; i < 3; i++) begin
        a_ls  = `SRAM_BASE + 32'(16 * i + 256);
        a_if  = a_ls + 32'd8;
        data  = $random(seed);
        stall = 1 + ($unsigned($random(seed)) % 8);
        write_check("backpressure setup", a_if, $random(seed), 4'hf, 2);
        // stalled write, fetch read arrives a cycle later and waits
        fork
            ls_write("backpressure write", a_ls, data, 4'hf, i % 3, stall, got_b);
            begin
                @(posedge clk);
                do_read("backpressure fetch", 1'b0, a_if, 0, got_if, done_if);
            end
        join
        shadow_write(a_ls, data, 4'hf);
        check_b($sformatf("backpressure write %0d", i), exp_b, got_b);
        exp_r.data = shadow[word_of(a_if)];
        check_r($sformatf("backpressure fetch %0d", i), exp_r, got_if);
        stall = 1 + ($unsigned($random(seed)) % 8);
        fork
            do_read("backpressure ls", 1'b1, a_ls, stall, got_ls, done_ls);
            begin
                @(posedge clk);
                do_read("backpressure fetch", 1'b0, a_if, 0, got_if, done_if);
            end
        join
        check_r($sformatf("backpressure fetch again %0d", i), exp_r, got_if);
        check_flag($sformatf("backpressure fetch waited %0d", i), 1'b1, done_if > done_ls);
        exp_r.data = shadow[word_of(a_ls)];
        check_r($sformatf("backpressure ls %0d", i), exp_r, got_ls);
    end
endtask

`endif

// ==== testbench/tb_mem_subsys.sv ====
`timescale 1ns/1ps
`include "mem_bus_defs.svh"

module tb_mem_subsys;

    localparam int TIMEOUT = 100;
    localparam int IDX_W   = $clog2(`SRAM_WORDS);

    logic                 clk;
    logic                 rst;
    logic                 if_ar_valid;
    logic                 if_ar_ready;
    mem_bus_pkg::axi_ar_t if_ar;
    logic                 if_r_valid;
    logic                 if_r_ready;
    mem_bus_pkg::axi_r_t  if_r;
    logic                 ls_ar_valid;
    logic                 ls_ar_ready;
    mem_bus_pkg::axi_ar_t ls_ar;
    logic                 ls_r_valid;
    logic                 ls_r_ready;
    mem_bus_pkg::axi_r_t  ls_r;
    logic                 ls_aw_valid;
    logic                 ls_aw_ready;
    mem_bus_pkg::axi_aw_t ls_aw;
    logic                 ls_w_valid;
    logic                 ls_w_ready;
    mem_bus_pkg::axi_w_t  ls_w;
    logic                 ls_b_valid;
    logic                 ls_b_ready;
    mem_bus_pkg::axi_b_t  ls_b;

    // expected array contents
    logic [`MEM_DATA_W-1:0] shadow [`SRAM_WORDS];

    integer seed       = 45456;
    int     mismatches = 0;
    int     timeouts   = 0;
    // response transfers seen on either port
    int     xfer_count = 0;

    mem_subsys_top uut (.*);

    always #10 clk = ~clk;

    task automatic timeout_error(input string what);
        timeouts++;
        $display("timeout: %s did not complete within %0d cycles", what, TIMEOUT);
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_r(input string name, input mem_bus_pkg::axi_r_t exp,
                           input mem_bus_pkg::axi_r_t act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch %s: expected data %h resp %b, actual data %h resp %b",
                     name, exp.data, exp.resp, act.data, act.resp);
        end
    endtask

    task automatic check_b(input string name, input mem_bus_pkg::axi_b_t exp,
                           input mem_bus_pkg::axi_b_t act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch %s: expected resp %b, actual resp %b", name, exp.resp, act.resp);
        end
    endtask

    function automatic logic [IDX_W-1:0] word_of(input logic [`MEM_ADDR_W-1:0] addr);
        return IDX_W'((addr - `SRAM_BASE) >> 2);
    endfunction

    // lanes with a strobe bit set take the new byte
    task automatic shadow_write(input logic [`MEM_ADDR_W-1:0] addr,
                                input logic [`MEM_DATA_W-1:0] data,
                                input logic [`MEM_STRB_W-1:0] strb);
        for (int i = 0; i < `MEM_STRB_W; i++) begin
            if (strb[i]) begin
                shadow[word_of(addr)][i*8 +: 8] = data[i*8 +: 8];
            end
        end
    endtask

    // one read, ls = 0 for the fetch port and 1 for load/store
    task automatic do_read(input string name, input bit ls,
                           input logic [`MEM_ADDR_W-1:0] addr, input int stall,
                           output mem_bus_pkg::axi_r_t resp, output int done_at);
        int                  n;
        logic                got;
        mem_bus_pkg::axi_r_t first;
        resp    = '0;
        done_at = 0;
        got     = 1'b0;
        @(posedge clk);
        #1;
        if (ls) begin
            ls_ar_valid = 1'b1;
            ls_ar.addr  = addr;
        end else begin
            if_ar_valid = 1'b1;
            if_ar.addr  = addr;
        end
        for (n = 0; n < TIMEOUT && !got; n++) begin
            @(negedge clk);
            got = ls ? ls_ar_ready : if_ar_ready;
        end
        @(posedge clk);
        #1;
        if (ls) ls_ar_valid = 1'b0;
        else if_ar_valid = 1'b0;
        if (!got) begin
            timeout_error({name, " read address"});
            return;
        end
        got = 1'b0;
        for (n = 0; n < TIMEOUT && !got; n++) begin
            @(negedge clk);
            got = ls ? ls_r_valid : if_r_valid;
        end
        if (!got) begin
            timeout_error({name, " read data"});
            return;
        end
        // rready still low, response must hold
        first = ls ? ls_r : if_r;
        repeat (stall) begin
            @(negedge clk);
            check_flag({name, " rvalid held"}, 1'b1, ls ? ls_r_valid : if_r_valid);
            check_r({name, " r held"}, first, ls ? ls_r : if_r);
        end
        @(posedge clk);
        #1;
        if (ls) ls_r_ready = 1'b1;
        else if_r_ready = 1'b1;
        @(negedge clk);
        check_flag({name, " rvalid at transfer"}, 1'b1, ls ? ls_r_valid : if_r_valid);
        resp = ls ? ls_r : if_r;
        @(posedge clk);
        xfer_count++;
        done_at = xfer_count;
        #1;
        if (ls) ls_r_ready = 1'b0;
        else if_r_ready = 1'b0;
    endtask

    // order 0 sends AW first, 1 sends W first, 2 sends both together
    task automatic ls_write(input string name, input logic [`MEM_ADDR_W-1:0] addr,
                            input logic [`MEM_DATA_W-1:0] data,
                            input logic [`MEM_STRB_W-1:0] strb, input int order,
                            input int stall, output mem_bus_pkg::axi_b_t resp);
        int                  n;
        logic                aw_done;
        logic                w_done;
        logic                aw_hit;
        logic                w_hit;
        logic                got;
        mem_bus_pkg::axi_b_t first;
        aw_done = 1'b0;
        w_done  = 1'b0;
        got     = 1'b0;
        resp    = '0;
        @(posedge clk);
        #1;
        ls_aw.addr  = addr;
        ls_w.data   = data;
        ls_w.strb   = strb;
        ls_aw_valid = order != 1;
        ls_w_valid  = order != 0;
        for (n = 0; n < TIMEOUT && !(aw_done && w_done); n++) begin
            @(negedge clk);
            aw_hit = ls_aw_valid && ls_aw_ready;
            w_hit  = ls_w_valid && ls_w_ready;
            @(posedge clk);
            #1;
            aw_done = aw_done || aw_hit;
            w_done  = w_done || w_hit;
            // second half only once the first is taken
            ls_aw_valid = !aw_done && (ls_aw_valid || w_done);
            ls_w_valid  = !w_done && (ls_w_valid || aw_done);
        end
        if (!(aw_done && w_done)) begin
            ls_aw_valid = 1'b0;
            ls_w_valid  = 1'b0;
            timeout_error({name, " write address and data"});
            return;
        end
        for (n = 0; n < TIMEOUT && !got; n++) begin
            @(negedge clk);
            got = ls_b_valid;
        end
        if (!got) begin
            timeout_error({name, " write response"});
            return;
        end
        first = ls_b;
        repeat (stall) begin
            @(negedge clk);
            check_flag({name, " bvalid held"}, 1'b1, ls_b_valid);
            check_b({name, " b held"}, first, ls_b);
        end
        @(posedge clk);
        #1;
        ls_b_ready = 1'b1;
        @(negedge clk);
        check_flag({name, " bvalid at transfer"}, 1'b1, ls_b_valid);
        resp = ls_b;
        @(posedge clk);
        xfer_count++;
        #1;
        ls_b_ready = 1'b0;
    endtask

    task automatic read_check(input string name, input bit ls,
                              input logic [`MEM_ADDR_W-1:0] addr);
        mem_bus_pkg::axi_r_t exp;
        mem_bus_pkg::axi_r_t act;
        int                  done_at;
        exp.data = shadow[word_of(addr)];
        exp.resp = mem_bus_pkg::OKAY;
        do_read(name, ls, addr, 0, act, done_at);
        check_r(name, exp, act);
    endtask

    task automatic write_check(input string name, input logic [`MEM_ADDR_W-1:0] addr,
                               input logic [`MEM_DATA_W-1:0] data,
                               input logic [`MEM_STRB_W-1:0] strb, input int order);
        mem_bus_pkg::axi_b_t exp;
        mem_bus_pkg::axi_b_t act;
        exp.resp = mem_bus_pkg::OKAY;
        ls_write(name, addr, data, strb, order, 0, act);
        shadow_write(addr, data, strb);
        check_b(name, exp, act);
    endtask

    `include "tb_mem_tests.svh"

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        if_ar_valid = 1'b0;
        if_ar       = '0;
        if_r_ready  = 1'b0;
        ls_ar_valid = 1'b0;
        ls_ar       = '0;
        ls_r_ready  = 1'b0;
        ls_aw_valid = 1'b0;
        ls_aw       = '0;
        ls_w_valid  = 1'b0;
        ls_w        = '0;
        ls_b_ready  = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset();
        test_write_read();
        test_strobes();
        test_shared();
        test_out_of_window();
        test_backpressure();
        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== verilog/mem_bus_arbiter.sv ====
`timescale 1ns/1ps

module mem_bus_arbiter (
    input  logic                 clk,
    input  logic                 rst,

    // fetch
    input  logic                 if_ar_valid,
    output logic                 if_ar_ready,
    input  mem_bus_pkg::axi_ar_t if_ar,
    output logic                 if_r_valid,
    input  logic                 if_r_ready,
    output mem_bus_pkg::axi_r_t  if_r,

    // load/store
    input  logic                 ls_ar_valid,
    output logic                 ls_ar_ready,
    input  mem_bus_pkg::axi_ar_t ls_ar,
    output logic                 ls_r_valid,
    input  logic                 ls_r_ready,
    output mem_bus_pkg::axi_r_t  ls_r,
    input  logic                 ls_aw_valid,
    output logic                 ls_aw_ready,
    input  mem_bus_pkg::axi_aw_t ls_aw,
    input  logic                 ls_w_valid,
    output logic                 ls_w_ready,
    input  mem_bus_pkg::axi_w_t  ls_w,
    output logic                 ls_b_valid,
    input  logic                 ls_b_ready,
    output mem_bus_pkg::axi_b_t  ls_b,

    // toward the slave
    output logic                 m_ar_valid,
    input  logic                 m_ar_ready,
    output mem_bus_pkg::axi_ar_t m_ar,
    input  logic                 m_r_valid,
    output logic                 m_r_ready,
    input  mem_bus_pkg::axi_r_t  m_r,
    output logic                 m_aw_valid,
    input  logic                 m_aw_ready,
    output mem_bus_pkg::axi_aw_t m_aw,
    output logic                 m_w_valid,
    input  logic                 m_w_ready,
    output mem_bus_pkg::axi_w_t  m_w,
    input  logic                 m_b_valid,
    output logic                 m_b_ready,
    input  mem_bus_pkg::axi_b_t  m_b
);

    // owner codes, also the request bit positions
    localparam logic [1:0] OWN_IF = 2'd0;
    localparam logic [1:0] OWN_LR = 2'd1;
    localparam logic [1:0] OWN_LW = 2'd2;

    logic       busy;
    logic [1:0] owner;
    logic [1:0] rr_ptr;
    logic [2:0] req;
    logic [1:0] winner;
    logic       resp_done;
    logic       own_if;
    logic       own_lr;
    logic       own_lw;

    function automatic logic [1:0] next_idx(input logic [1:0] idx);
        return (idx == 2'd2) ? 2'd0 : idx + 2'd1;
    endfunction

    // a write counts as soon as either half shows up
    assign req = {ls_aw_valid || ls_w_valid, ls_ar_valid, if_ar_valid};

    // search starts at the pointer and wraps
    always_comb begin
        logic [1:0] c1;
        logic [1:0] c2;
        c1 = next_idx(rr_ptr);
        c2 = next_idx(c1);
        if (req[rr_ptr]) begin
            winner = rr_ptr;
        end else if (req[c1]) begin
            winner = c1;
        end else begin
            winner = c2;
        end
    end

    assign own_if = busy && owner == OWN_IF;
    assign own_lr = busy && owner == OWN_LR;
    assign own_lw = busy && owner == OWN_LW;

    // only the owner's response channel can complete
    assign resp_done = (m_r_valid && m_r_ready) || (m_b_valid && m_b_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            owner  <= OWN_IF;
            rr_ptr <= 2'd0;
        end else if (!busy) begin
            if (|req) begin
                busy   <= 1'b1;
                owner  <= winner;
                rr_ptr <= next_idx(winner);
            end
        end else if (resp_done) begin
            busy <= 1'b0;
        end
    end

    // read address mux
    assign m_ar_valid  = (own_if && if_ar_valid) || (own_lr && ls_ar_valid);
    assign m_ar        = own_lr ? ls_ar : if_ar;
    assign if_ar_ready = own_if && m_ar_ready;
    assign ls_ar_ready = own_lr && m_ar_ready;

    // read data back to its owner
    assign if_r_valid = own_if && m_r_valid;
    assign if_r       = m_r;
    assign ls_r_valid = own_lr && m_r_valid;
    assign ls_r       = m_r;
    assign m_r_ready  = (own_if && if_r_ready) || (own_lr && ls_r_ready);

    // write channels belong to load/store only
    assign m_aw_valid  = own_lw && ls_aw_valid;
    assign m_aw        = ls_aw;
    assign ls_aw_ready = own_lw && m_aw_ready;

    assign m_w_valid  = own_lw && ls_w_valid;
    assign m_w        = ls_w;
    assign ls_w_ready = own_lw && m_w_ready;

    assign ls_b_valid = own_lw && m_b_valid;
    assign ls_b       = m_b;
    assign m_b_ready  = own_lw && ls_b_ready;

    a_ready_owner: assert property (@(posedge clk) disable iff (rst)
        (!if_ar_ready || own_if) && (!ls_ar_ready || own_lr)
        && (!(ls_aw_ready || ls_w_ready) || own_lw));

endmodule

// ==== verilog/mem_bus_pkg.sv ====
`include "mem_bus_defs.svh"

package mem_bus_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    // read address
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
    } axi_ar_t;

    // read data
    typedef struct packed {
        logic [`MEM_DATA_W-1:0] data;
        axi_resp_e              resp;
    } axi_r_t;

    // write address
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
    } axi_aw_t;

    // write data, one strobe bit per byte lane
    typedef struct packed {
        logic [`MEM_DATA_W-1:0] data;
        logic [`MEM_STRB_W-1:0] strb;
    } axi_w_t;

    // write response
    typedef struct packed {
        axi_resp_e resp;
    } axi_b_t;

endpackage

// ==== verilog/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic                 clk,
    input  logic                 rst,

    // fetch port, read only
    input  logic                 if_ar_valid,
    output logic                 if_ar_ready,
    input  mem_bus_pkg::axi_ar_t if_ar,
    output logic                 if_r_valid,
    input  logic                 if_r_ready,
    output mem_bus_pkg::axi_r_t  if_r,

    // load/store port
    input  logic                 ls_ar_valid,
    output logic                 ls_ar_ready,
    input  mem_bus_pkg::axi_ar_t ls_ar,
    output logic                 ls_r_valid,
    input  logic                 ls_r_ready,
    output mem_bus_pkg::axi_r_t  ls_r,
    input  logic                 ls_aw_valid,
    output logic                 ls_aw_ready,
    input  mem_bus_pkg::axi_aw_t ls_aw,
    input  logic                 ls_w_valid,
    output logic                 ls_w_ready,
    input  mem_bus_pkg::axi_w_t  ls_w,
    output logic                 ls_b_valid,
    input  logic                 ls_b_ready,
    output mem_bus_pkg::axi_b_t  ls_b
);

    // arbiter to sram
    logic                 m_ar_valid;
    logic                 m_ar_ready;
    mem_bus_pkg::axi_ar_t m_ar;
    logic                 m_r_valid;
    logic                 m_r_ready;
    mem_bus_pkg::axi_r_t  m_r;
    logic                 m_aw_valid;
    logic                 m_aw_ready;
    mem_bus_pkg::axi_aw_t m_aw;
    logic                 m_w_valid;
    logic                 m_w_ready;
    mem_bus_pkg::axi_w_t  m_w;
    logic                 m_b_valid;
    logic                 m_b_ready;
    mem_bus_pkg::axi_b_t  m_b;

    // all port names match one to one
    mem_bus_arbiter u_arb (.*);

    sram_axi_slave u_sram (
        .clk      (clk),
        .rst      (rst),
        .ar_valid (m_ar_valid),
        .ar_ready (m_ar_ready),
        .ar       (m_ar),
        .r_valid  (m_r_valid),
        .r_ready  (m_r_ready),
        .r        (m_r),
        .aw_valid (m_aw_valid),
        .aw_ready (m_aw_ready),
        .aw       (m_aw),
        .w_valid  (m_w_valid),
        .w_ready  (m_w_ready),
        .w        (m_w),
        .b_valid  (m_b_valid),
        .b_ready  (m_b_ready),
        .b        (m_b)
    );

endmodule

// ==== verilog/sram_axi_slave.sv ====
`timescale 1ns/1ps
`include "mem_bus_defs.svh"

module sram_axi_slave (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 ar_valid,
    output logic                 ar_ready,
    input  mem_bus_pkg::axi_ar_t ar,

    output logic                 r_valid,
    input  logic                 r_ready,
    output mem_bus_pkg::axi_r_t  r,

    input  logic                 aw_valid,
    output logic                 aw_ready,
    input  mem_bus_pkg::axi_aw_t aw,

    input  logic                 w_valid,
    output logic                 w_ready,
    input  mem_bus_pkg::axi_w_t  w,

    output logic                 b_valid,
    input  logic                 b_ready,
    output mem_bus_pkg::axi_b_t  b
);

    localparam int IDX_W = $clog2(`SRAM_WORDS);
    localparam int CNT_W = $clog2(`SRAM_RD_LAT + 1);
    localparam logic [`MEM_ADDR_W-1:0] WIN_BYTES = `MEM_ADDR_W'(`SRAM_WORDS * 4);

    logic [`MEM_DATA_W-1:0] mem [`SRAM_WORDS];

    logic [`MEM_ADDR_W-1:0] rd_addr;
    logic [CNT_W-1:0]       rd_cnt;
    logic [`MEM_ADDR_W-1:0] wr_addr;
    logic [`MEM_DATA_W-1:0] wr_data;
    logic [`MEM_STRB_W-1:0] wr_strb;
    logic                   aw_got;
    logic                   w_got;

    logic                   ar_fire;
    logic                   r_fire;
    logic                   aw_fire;
    logic                   w_fire;
    logic                   b_fire;
    logic                   rd_done;
    logic                   wr_go;
    logic                   rd_in_win;
    logic                   wr_in_win;
    logic [IDX_W-1:0]       rd_idx;
    logic [IDX_W-1:0]       wr_idx;

    // offset from base wraps, so one unsigned compare covers both ends
    function automatic logic in_window(input logic [`MEM_ADDR_W-1:0] addr);
        logic [`MEM_ADDR_W-1:0] off;
        off = addr - `SRAM_BASE;
        return off < WIN_BYTES;
    endfunction

    function automatic logic [IDX_W-1:0] word_index(input logic [`MEM_ADDR_W-1:0] addr);
        logic [`MEM_ADDR_W-1:0] off;
        off = addr - `SRAM_BASE;
        return off[IDX_W+1:2];
    endfunction

    assign ar_fire = ar_valid && ar_ready;
    assign r_fire  = r_valid && r_ready;
    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;
    assign b_fire  = b_valid && b_ready;

    // last latency cycle
    assign rd_done = rd_cnt == CNT_W'(1);
    // both halves of the write are in
    assign wr_go   = aw_got && w_got;

    assign rd_in_win = in_window(rd_addr);
    assign wr_in_win = in_window(wr_addr);
    assign rd_idx    = word_index(rd_addr);
    assign wr_idx    = word_index(wr_addr);

    // read side: one outstanding read, counter models slow sram
    always_ff @(posedge clk) begin
        if (rst) begin
            ar_ready <= 1'b1;
            r_valid  <= 1'b0;
            rd_cnt   <= '0;
        end else begin
            if (ar_fire) begin
                ar_ready <= 1'b0;
                rd_cnt   <= CNT_W'(`SRAM_RD_LAT);
            end else if (rd_cnt != '0) begin
                rd_cnt <= rd_cnt - CNT_W'(1);
            end

            if (rd_done) begin
                r_valid <= 1'b1;
            end else if (r_fire) begin
                r_valid  <= 1'b0;
                ar_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_addr <= ar.addr;
        end
    end

    // write side: AW and W may land in either order
    always_ff @(posedge clk) begin
        if (rst) begin
            aw_ready <= 1'b1;
            w_ready  <= 1'b1;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            b_valid  <= 1'b0;
        end else begin
            if (aw_fire) begin
                aw_ready <= 1'b0;
                aw_got   <= 1'b1;
            end
            if (w_fire) begin
                w_ready <= 1'b0;
                w_got   <= 1'b1;
            end

            if (wr_go) begin
                aw_got  <= 1'b0;
                w_got   <= 1'b0;
                b_valid <= 1'b1;
            end else if (b_fire) begin
                b_valid  <= 1'b0;
                aw_ready <= 1'b1;
                w_ready  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            wr_addr <= aw.addr;
        end
        if (w_fire) begin
            wr_data <= w.data;
            wr_strb <= w.strb;
        end
    end

    // array access and response payloads
    always_ff @(posedge clk) begin
        if (wr_go) begin
            if (wr_in_win) begin
                for (int i = 0; i < `MEM_STRB_W; i++) begin
                    if (wr_strb[i]) begin
                        mem[wr_idx][i*8 +: 8] <= wr_data[i*8 +: 8];
                    end
                end
                b.resp <= mem_bus_pkg::OKAY;
            end else begin
                b.resp <= mem_bus_pkg::SLVERR;
            end
        end

        if (rd_done) begin
            if (rd_in_win) begin
                r.data <= mem[rd_idx];
                r.resp <= mem_bus_pkg::OKAY;
            end else begin
                r.data <= '0;
                r.resp <= mem_bus_pkg::SLVERR;
            end
        end
    end

    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        r_valid && !r_ready |=> r_valid && $stable(r));

    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        b_valid && !b_ready |=> b_valid && $stable(b));

    // a pending response must never see a new latency count
    a_no_reload: assert property (@(posedge clk) disable iff (rst)
        r_valid |=> rd_cnt == '0);

endmodule
